//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_dma_backend
RTL_TOP    := dma_backend_top
FILELIST   := filelist.f
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_dma_backend.sv
// Testbench for the copy engine top level.
// Issues aligned, misaligned, illegal and mixed copies onto a stalling memory,
// checks each response against a byte-level shadow copy, then the memory.

`timescale 1ns/1ns
`default_nettype none

module tb_dma_backend;

    import dma_cfg_pkg::*;

    localparam logic [31:0] SEED         = 32'ha364_b4f5;
    localparam int unsigned MEM_WORDS    = 64;
    localparam int unsigned MEM_BYTES    = MEM_WORDS * STRB_W;
    // sources from the lower half and destinations from the upper half
    localparam int unsigned HALF_WORDS   = MEM_WORDS / 2;
    localparam int unsigned N_ALIGNED    = 16;
    localparam int unsigned N_MISALIGNED = 48;
    localparam int unsigned N_ILLEGAL    = 16;
    localparam int unsigned N_MIXED      = 40;
    localparam int unsigned N_TOTAL      = N_ALIGNED + N_MISALIGNED + N_ILLEGAL + N_MIXED;
    localparam int unsigned CYCLE_LIMIT  = 200 * N_TOTAL;

    logic       clk_i;
    logic       rst_n_i;
    logic       req_valid_i;
    logic       req_ready_o;
    addr_t      req_src_addr_i;
    addr_t      req_dst_addr_i;
    len_t       req_len_i;
    logic       rsp_valid_o;
    logic       rsp_ready_i;
    logic       rsp_error_o;
    logic       mem_req_o;
    logic       mem_we_o;
    addr_t      mem_addr_o;
    data_t      mem_wdata_o;
    strb_t      mem_be_o;
    logic       mem_gnt_i;
    data_t      mem_rdata_i;
    logic       mem_rvalid_i;

    logic [7:0]  shadow [MEM_BYTES];
    bit          exp_err_q [$];
    string       exp_name_q [$];
    int          stim_seed;
    int          bp_seed;
    int unsigned errors     = 0;
    int unsigned rsp_errors = 0;
    int unsigned n_issued   = 0;
    int unsigned n_good     = 0;
    int unsigned n_rsp      = 0;
    int unsigned n_writes   = 0;
    int unsigned cycle_cnt  = 0;

    dma_backend_top #(.FIFO_DEPTH(2)) u_dma_backend_top (
        .clk_i, .rst_n_i,
        .req_valid_i, .req_ready_o, .req_src_addr_i, .req_dst_addr_i, .req_len_i,
        .rsp_valid_o, .rsp_ready_i, .rsp_error_o,
        .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_be_o,
        .mem_gnt_i, .mem_rdata_i, .mem_rvalid_i
    );

    tb_mem_model #(.WORDS(MEM_WORDS), .SEED(SEED)) u_mem (
        .clk_i, .rst_n_i,
        .mem_req_i   (mem_req_o),   .mem_we_i    (mem_we_o),    .mem_addr_i   (mem_addr_o),
        .mem_wdata_i (mem_wdata_o), .mem_be_i    (mem_be_o),    .mem_gnt_o    (mem_gnt_i),
        .mem_rdata_o (mem_rdata_i), .mem_rvalid_o (mem_rvalid_i)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #2;
            clk_i = ~clk_i;
        end
    end

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(stim_seed)) % n;
    endfunction

    function automatic addr_t word_byte_addr(input int unsigned word, input int unsigned off);
        return addr_t'(word * STRB_W + off);
    endfunction

    // copies bytes in the shadow and returns 1 when an error response is due
    function automatic bit copy_ref(input addr_t src, input addr_t dst, input len_t len);
        int s_off;
        int d_off;
        int n;
        s_off = int'(src[OFFS_W-1:0]);
        d_off = int'(dst[OFFS_W-1:0]);
        n     = int'(len);
        if (n == 0 || s_off + n > STRB_W || d_off + n > STRB_W) begin
            return 1'b1;
        end
        for (int i = 0; i < n; i++) begin
            shadow[int'(dst) + i] = shadow[int'(src) + i];
        end
        return 1'b0;
    endfunction

    // ------------------------------
    // stimulus
    // ------------------------------
    // starts 1 ns after a rising edge and returns 1 ns after the accepting edge
    task automatic issue_copy(input string name, input addr_t src, input addr_t dst,
                              input len_t len);
        bit err;
        err = copy_ref(src, dst, len);
        exp_err_q.push_back(err);
        exp_name_q.push_back(name);
        n_issued++;
        if (!err) begin
            n_good++;
        end
        req_src_addr_i = src;
        req_dst_addr_i = dst;
        req_len_i      = len;
        req_valid_i    = 1'b1;
        @(negedge clk_i);
        while (!req_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic run_aligned();
        for (int k = 0; k < N_ALIGNED; k++) begin
            issue_copy("aligned", word_byte_addr(rand_below(HALF_WORDS), 0),
                       word_byte_addr(HALF_WORDS + rand_below(HALF_WORDS), 0), len_t'(STRB_W));
        end
    endtask

    task automatic run_misaligned();
        int unsigned s;
        int unsigned d;
        int unsigned room;
        for (int k = 0; k < N_MISALIGNED; k++) begin
            s    = rand_below(STRB_W);
            d    = rand_below(STRB_W);
            room = STRB_W - ((s > d) ? s : d);
            issue_copy("misaligned", word_byte_addr(rand_below(HALF_WORDS), s),
                       word_byte_addr(HALF_WORDS + rand_below(HALF_WORDS), d),
                       len_t'(1 + rand_below(room)));
        end
    endtask

    task automatic run_illegal();
        int unsigned s;
        int unsigned d;
        len_t        len;
        for (int k = 0; k < N_ILLEGAL; k++) begin
            s = rand_below(STRB_W);
            d = rand_below(STRB_W);
            if (k % 2 == 0) begin
                len = '0;
            end else begin
                // any length of two or more from the last byte crosses
                if (k % 4 == 1) begin
                    s = STRB_W - 1;
                end else begin
                    d = STRB_W - 1;
                end
                len = len_t'(2 + rand_below(6));
            end
            issue_copy("illegal", word_byte_addr(rand_below(HALF_WORDS), s),
                       word_byte_addr(HALF_WORDS + rand_below(HALF_WORDS), d), len);
        end
    endtask

    // any offsets and lengths whether legal or not
    task automatic run_mixed();
        int unsigned s;
        int unsigned d;
        for (int k = 0; k < N_MIXED; k++) begin
            s = rand_below(STRB_W);
            d = rand_below(STRB_W);
            issue_copy("mixed", word_byte_addr(rand_below(HALF_WORDS), s),
                       word_byte_addr(HALF_WORDS + rand_below(HALF_WORDS), d),
                       len_t'(rand_below(8)));
        end
    endtask

    task automatic load_shadow();
        data_t word_val;
        for (int a = 0; a < MEM_BYTES; a++) begin
            word_val  = u_mem.mem_q[a / STRB_W];
            shadow[a] = word_val[8 * (a % STRB_W) +: 8];
        end
    endtask

    task automatic check_memory();
        data_t      word_val;
        logic [7:0] got;
        for (int a = 0; a < MEM_BYTES; a++) begin
            word_val = u_mem.mem_q[a / STRB_W];
            got      = word_val[8 * (a % STRB_W) +: 8];
            if (got !== shadow[a]) begin
                $display("Fail memory byte 0x%0h: expected %02h, actual %02h", a, shadow[a], got);
                errors++;
            end
        end
    endtask

    // response back-pressure
    initial begin
        bp_seed     = SEED;
        rsp_ready_i = 1'b0;
        forever begin
            @(posedge clk_i);
            #1;
            rsp_ready_i = (($random(bp_seed) & 3) != 0) && rst_n_i;
        end
    end

    // ------------------------------
    // response compare
    // ------------------------------
    always @(negedge clk_i) begin
        bit    exp_err;
        string exp_name;
        if (rst_n_i && mem_req_o && mem_gnt_i && mem_we_o) begin
            n_writes++;
        end
        if (rst_n_i && rsp_valid_o && rsp_ready_i) begin
            n_rsp++;
            if (exp_err_q.size() == 0) begin
                $display("a response came with no request outstanding");
                rsp_errors++;
            end else begin
                exp_err  = exp_err_q.pop_front();
                exp_name = exp_name_q.pop_front();
                if (rsp_error_o !== exp_err) begin
                    $display("Fail %s: expected rsp_error_o %0b, actual %0b",
                             exp_name, exp_err, rsp_error_o);
                    rsp_errors++;
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d of %0d responses, %0d errors",
                     cycle_cnt, n_rsp, n_issued, errors + rsp_errors);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        stim_seed      = SEED;
        rst_n_i        = 1'b0;
        req_valid_i    = 1'b0;
        req_src_addr_i = '0;
        req_dst_addr_i = '0;
        req_len_i      = '0;
        repeat (5) begin
            @(posedge clk_i);
        end
        load_shadow();
        #1;
        rst_n_i = 1'b1;
        run_aligned();
        run_misaligned();
        run_illegal();
        run_mixed();
        while (n_rsp < n_issued) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        @(negedge clk_i);
        if (rsp_valid_o) begin
            $display("a response is still pending after the last expected one");
            errors++;
        end
        if (n_rsp != n_issued) begin
            $display("Fail responses: expected %0d, actual %0d", n_issued, n_rsp);
            errors++;
        end
        // one bus write per good copy so none is lost or repeated
        if (n_writes != n_good) begin
            $display("Fail writes: expected %0d, actual %0d", n_good, n_writes);
            errors++;
        end
        check_memory();
        $display("errors: %0d (%0d in responses, %0d in final checks)",
                 errors + rsp_errors, rsp_errors, errors);
        if (errors + rsp_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tb_mem_model.sv
// Memory model for the copy engine testbench.
// Word storage with byte enables, random grant stalls and read data one
// cycle after the grant. Every byte starts with a value of its own address.

`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
    parameter int unsigned WORDS = 64,
    parameter logic [31:0] SEED  = 32'h1
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               mem_req_i,
    input  logic               mem_we_i,
    input  dma_cfg_pkg::addr_t mem_addr_i,
    input  dma_cfg_pkg::data_t mem_wdata_i,
    input  dma_cfg_pkg::strb_t mem_be_i,
    output logic               mem_gnt_o,
    output dma_cfg_pkg::data_t mem_rdata_o,
    output logic               mem_rvalid_o
);

    import dma_cfg_pkg::*;

    localparam int unsigned IDX_W = $clog2(WORDS);

    data_t            mem_q [WORDS];
    int               gnt_seed;
    logic             acc;
    logic             acc_we;
    logic [IDX_W-1:0] acc_idx;
    data_t            acc_wdata;
    strb_t            acc_be;

    initial begin
        gnt_seed     = SEED;
        mem_gnt_o    = 1'b0;
        mem_rdata_o  = '0;
        mem_rvalid_o = 1'b0;
        // an odd multiplier maps each byte address to its own value
        for (int w = 0; w < WORDS; w++) begin
            for (int b = 0; b < STRB_W; b++) begin
                mem_q[w][8*b +: 8] = 8'((w * STRB_W + b) * 37 + 11);
            end
        end
        forever begin
            // bus inputs settle well before the falling edge
            @(negedge clk_i);
            acc       = mem_req_i & mem_gnt_o;
            acc_we    = mem_we_i;
            acc_idx   = mem_addr_i[OFFS_W +: IDX_W];
            acc_wdata = mem_wdata_i;
            acc_be    = mem_be_i;
            @(posedge clk_i);
            #1;
            if (acc && acc_we) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (acc_be[b]) begin
                        mem_q[acc_idx][8*b +: 8] = acc_wdata[8*b +: 8];
                    end
                end
            end
            // read data shows up for exactly one cycle
            mem_rvalid_o = acc & ~acc_we;
            if (acc && !acc_we) begin
                mem_rdata_o = mem_q[acc_idx];
            end
            // about one stall in four
            mem_gnt_o = (($random(gnt_seed) & 3) != 0) && rst_n_i;
        end
    end

endmodule

`default_nettype wire

//--- filelist.f
src/dma_cfg_pkg.sv
src/dma_bus_pkg.sv
src/dma_req_fifo.sv
src/dma_req_front.sv
src/dma_read_engine.sv
src/dma_write_engine.sv
src/dma_bus_arbiter.sv
src/dma_backend_top.sv
bench/tb_mem_model.sv
bench/tb_dma_backend.sv

//--- src/dma_backend_top.sv
// Copy engine top level: request front, three queues, read and write
// engines and the bus arbiter. FIFO_DEPTH sets the depth of all queues.

`timescale 1ns/1ns
`default_nettype none

module dma_backend_top #(
    parameter int unsigned FIFO_DEPTH = 2
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  dma_cfg_pkg::addr_t req_src_addr_i,
    input  dma_cfg_pkg::addr_t req_dst_addr_i,
    input  dma_cfg_pkg::len_t  req_len_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output logic               rsp_error_o,
    output logic               mem_req_o,
    output logic               mem_we_o,
    output dma_cfg_pkg::addr_t mem_addr_o,
    output dma_cfg_pkg::data_t mem_wdata_o,
    output dma_cfg_pkg::strb_t mem_be_o,
    input  logic               mem_gnt_i,
    input  dma_cfg_pkg::data_t mem_rdata_i,
    input  logic               mem_rvalid_i
);

    import dma_cfg_pkg::*;

    // front to queues
    logic      r_valid, r_ready, w_valid, w_ready;
    r_dp_req_t r_req;
    w_dp_req_t w_req;
    // queues to engines
    logic      r_ord_valid, r_ord_ready, w_ord_valid, w_ord_ready;
    r_dp_req_t r_ord;
    w_dp_req_t w_ord;
    // aligned data path
    logic      rd_data_valid, rd_data_ready, wr_data_valid, wr_data_ready;
    data_t     rd_data, wr_data;
    logic      done_valid, done_ready;
    // engine bus requests
    logic      rd_bus_req, rd_bus_gnt, wr_bus_req, wr_bus_gnt;
    addr_t     rd_bus_addr, wr_bus_addr;
    data_t     wr_bus_wdata;
    strb_t     wr_bus_be;

    dma_req_front u_front (
        .clk_i, .rst_n_i,
        .req_valid_i, .req_ready_o, .req_src_addr_i, .req_dst_addr_i, .req_len_i,
        .r_valid_o    (r_valid),
        .r_ready_i    (r_ready),
        .r_req_o      (r_req),
        .w_valid_o    (w_valid),
        .w_ready_i    (w_ready),
        .w_req_o      (w_req),
        .done_valid_i (done_valid),
        .done_ready_o (done_ready),
        .rsp_valid_o, .rsp_ready_i, .rsp_error_o
    );

    dma_req_fifo #(.payload_t(r_dp_req_t), .DEPTH(FIFO_DEPTH)) u_r_fifo (
        .clk_i, .rst_n_i,
        .push_valid_i (r_valid),     .push_ready_o (r_ready),     .push_data_i (r_req),
        .pop_valid_o  (r_ord_valid), .pop_ready_i  (r_ord_ready), .pop_data_o  (r_ord)
    );

    dma_req_fifo #(.payload_t(w_dp_req_t), .DEPTH(FIFO_DEPTH)) u_w_fifo (
        .clk_i, .rst_n_i,
        .push_valid_i (w_valid),     .push_ready_o (w_ready),     .push_data_i (w_req),
        .pop_valid_o  (w_ord_valid), .pop_ready_i  (w_ord_ready), .pop_data_o  (w_ord)
    );

    dma_req_fifo #(.payload_t(data_t), .DEPTH(FIFO_DEPTH)) u_data_fifo (
        .clk_i, .rst_n_i,
        .push_valid_i (rd_data_valid), .push_ready_o (rd_data_ready), .push_data_i (rd_data),
        .pop_valid_o  (wr_data_valid), .pop_ready_i  (wr_data_ready), .pop_data_o  (wr_data)
    );

    dma_read_engine u_read_engine (
        .clk_i, .rst_n_i,
        .ord_valid_i  (r_ord_valid),   .ord_ready_o  (r_ord_ready),   .ord_i (r_ord),
        .bus_req_o    (rd_bus_req),    .bus_addr_o   (rd_bus_addr),   .bus_gnt_i (rd_bus_gnt),
        .bus_rvalid_i (mem_rvalid_i),  .bus_rdata_i  (mem_rdata_i),
        .data_valid_o (rd_data_valid), .data_ready_i (rd_data_ready), .data_o (rd_data)
    );

    dma_write_engine u_write_engine (
        .clk_i, .rst_n_i,
        .ord_valid_i  (w_ord_valid),   .ord_ready_o  (w_ord_ready),   .ord_i (w_ord),
        .data_valid_i (wr_data_valid), .data_ready_o (wr_data_ready), .data_i (wr_data),
        .bus_req_o    (wr_bus_req),    .bus_addr_o   (wr_bus_addr),
        .bus_wdata_o  (wr_bus_wdata),  .bus_be_o     (wr_bus_be),     .bus_gnt_i (wr_bus_gnt),
        .done_valid_o (done_valid),    .done_ready_i (done_ready)
    );

    dma_bus_arbiter u_bus_arbiter (
        .clk_i, .rst_n_i,
        .rd_req_i   (rd_bus_req),   .rd_addr_i (rd_bus_addr), .rd_gnt_o (rd_bus_gnt),
        .wr_req_i   (wr_bus_req),   .wr_addr_i (wr_bus_addr),
        .wr_wdata_i (wr_bus_wdata), .wr_be_i   (wr_bus_be),   .wr_gnt_o (wr_bus_gnt),
        .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o, .mem_be_o, .mem_gnt_i
    );

endmodule

`default_nettype wire

//--- src/dma_bus_arbiter.sv
// Round-robin arbiter for the one memory bus.
// The read and write engines are peers; on a tie the engine that did not
// win last gets the bus. A stalled winner keeps the bus until granted.

`timescale 1ns/1ns
`default_nettype none

module dma_bus_arbiter (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               rd_req_i,
    input  dma_cfg_pkg::addr_t rd_addr_i,
    output logic               rd_gnt_o,
    input  logic               wr_req_i,
    input  dma_cfg_pkg::addr_t wr_addr_i,
    input  dma_cfg_pkg::data_t wr_wdata_i,
    input  dma_cfg_pkg::strb_t wr_be_i,
    output logic               wr_gnt_o,
    output logic               mem_req_o,
    output logic               mem_we_o,
    output dma_cfg_pkg::addr_t mem_addr_o,
    output dma_cfg_pkg::data_t mem_wdata_o,
    output dma_cfg_pkg::strb_t mem_be_o,
    input  logic               mem_gnt_i
);

    import dma_bus_pkg::*;

    logic [BUS_REQS-1:0] reqs;
    bus_owner_e          winner;
    bus_owner_e          last_q;
    bus_owner_e          hold_q;
    logic                locked_q;

    assign reqs = {wr_req_i, rd_req_i};

    // ------------------------------
    // winner select
    // ------------------------------
    always_comb begin
        if (locked_q) begin
            winner = hold_q;
        end else if (rd_req_i && wr_req_i) begin
            winner = (last_q == OWNER_READ) ? OWNER_WRITE : OWNER_READ;
        end else if (wr_req_i) begin
            winner = OWNER_WRITE;
        end else begin
            winner = OWNER_READ;
        end
    end

    // ------------------------------
    // bus mux
    // ------------------------------
    assign mem_req_o   = |reqs;
    assign mem_we_o    = (winner == OWNER_WRITE);
    assign mem_addr_o  = mem_we_o ? wr_addr_i : rd_addr_i;
    assign mem_wdata_o = wr_wdata_i;
    // reads fetch the full word
    assign mem_be_o    = mem_we_o ? wr_be_i : '1;
    assign rd_gnt_o    = mem_gnt_i & rd_req_i & (winner == OWNER_READ);
    assign wr_gnt_o    = mem_gnt_i & wr_req_i & (winner == OWNER_WRITE);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // read goes first after reset
            last_q   <= OWNER_WRITE;
            hold_q   <= OWNER_READ;
            locked_q <= 1'b0;
        end else if (mem_req_o && mem_gnt_i) begin
            last_q   <= winner;
            locked_q <= 1'b0;
        end else if (mem_req_o) begin
            // stalled, keep the same owner on the bus
            hold_q   <= winner;
            locked_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/dma_bus_pkg.sv
// Memory bus arbitration definitions.
// Holds the number of bus requesters and the owner encoding.

`default_nettype none

package dma_bus_pkg;

    // read engine and write engine
    localparam int unsigned BUS_REQS = 2;

    // bus owner, also the last-winner state of the arbiter
    typedef enum logic [$clog2(BUS_REQS)-1:0] {
        OWNER_READ,
        OWNER_WRITE
    } bus_owner_e;

endpackage

`default_nettype wire

//--- src/dma_cfg_pkg.sv
// Widths and datapath order types shared by the copy engine blocks.
// Modules import this package inside their bodies; ports use scoped names.

`default_nettype none

package dma_cfg_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int unsigned ADDR_W = 24;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;
    localparam int unsigned OFFS_W = $clog2(STRB_W);
    // one extra bit so a full word length fits
    localparam int unsigned LEN_W  = OFFS_W + 1;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [OFFS_W-1:0] offs_t;
    typedef logic [LEN_W-1:0]  len_t;

    // ------------------------------
    // datapath orders
    // ------------------------------
    // read order: source word address plus byte rotation
    typedef struct packed {
        addr_t addr;
        offs_t shift;
    } r_dp_req_t;

    // write order: destination word address and inclusive byte range
    typedef struct packed {
        addr_t addr;
        offs_t first;
        offs_t last;
    } w_dp_req_t;

endpackage

`default_nettype wire

//--- src/dma_read_engine.sv
// Read side of the copy engine.
// Pops a read order, fetches the source word over the bus and rotates it
// into destination alignment before pushing it to the data queue.

`timescale 1ns/1ns
`default_nettype none

module dma_read_engine (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   ord_valid_i,
    output logic                   ord_ready_o,
    input  dma_cfg_pkg::r_dp_req_t ord_i,
    output logic                   bus_req_o,
    output dma_cfg_pkg::addr_t     bus_addr_o,
    input  logic                   bus_gnt_i,
    input  logic                   bus_rvalid_i,
    input  dma_cfg_pkg::data_t     bus_rdata_i,
    output logic                   data_valid_o,
    input  logic                   data_ready_i,
    output dma_cfg_pkg::data_t     data_o
);

    import dma_cfg_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e              state_q;
    r_dp_req_t           ord_q;
    data_t               data_q;
    logic                data_valid_q;
    logic [2*DATA_W-1:0] rot_wide;

    // only take a new order once the last word has left
    assign ord_ready_o  = (state_q == ST_IDLE) & ~data_valid_q;
    assign bus_req_o    = (state_q == ST_REQ);
    assign bus_addr_o   = ord_q.addr;
    assign data_valid_o = data_valid_q;
    assign data_o       = data_q;

    // rotate right by shift bytes, doubled word gives the wrap
    assign rot_wide = {bus_rdata_i, bus_rdata_i} >> {ord_q.shift, 3'b000};

    // order and data payload
    always_ff @(posedge clk_i) begin
        if (ord_valid_i && ord_ready_o) begin
            ord_q <= ord_i;
        end
        if (state_q == ST_WAIT && bus_rvalid_i) begin
            data_q <= rot_wide[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            data_valid_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (ord_valid_i && ord_ready_o) state_q <= ST_REQ;
                ST_REQ:  if (bus_gnt_i) state_q <= ST_WAIT;
                ST_WAIT: if (bus_rvalid_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
            // word held until the data queue takes it
            if (state_q == ST_WAIT && bus_rvalid_i) begin
                data_valid_q <= 1'b1;
            end else if (data_ready_i) begin
                data_valid_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dma_req_fifo.sv
// Small valid/ready FIFO, circular buffer with a fill count.
// The payload type is a parameter, so one module serves every queue.

`timescale 1ns/1ns
`default_nettype none

module dma_req_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 2
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_valid_i,
    output logic     push_ready_o,
    input  payload_t push_data_i,
    output logic     pop_valid_o,
    input  logic     pop_ready_i,
    output payload_t pop_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W:0]   CNT_FULL = (PTR_W + 1)'(DEPTH);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             push;
    logic             pop;

    // ready only depends on the fill level
    assign push_ready_o = (count_q != CNT_FULL);
    assign pop_valid_o  = (count_q != '0);
    assign pop_data_o   = mem_q[rd_ptr_q];

    assign push = push_valid_i & push_ready_o;
    assign pop  = pop_valid_o & pop_ready_i;

    // storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    // pointers and count
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            // both at once leaves the level unchanged
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dma_req_front.sv
// Request intake of the copy engine.
// Checks each request, rejects zero length and word crossing with an error,
// forks good ones into the read and write order queues, merges responses.

`timescale 1ns/1ns
`default_nettype none

module dma_req_front (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  dma_cfg_pkg::addr_t    req_src_addr_i,
    input  dma_cfg_pkg::addr_t    req_dst_addr_i,
    input  dma_cfg_pkg::len_t     req_len_i,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    output dma_cfg_pkg::r_dp_req_t r_req_o,
    output logic                  w_valid_o,
    input  logic                  w_ready_i,
    output dma_cfg_pkg::w_dp_req_t w_req_o,
    input  logic                  done_valid_i,
    output logic                  done_ready_o,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output logic                  rsp_error_o
);

    import dma_cfg_pkg::*;

    // room for every copy that can sit in the queues and engines
    localparam int unsigned OUT_W = 8;

    offs_t            src_offs;
    offs_t            dst_offs;
    logic [LEN_W:0]   src_end;
    logic [LEN_W:0]   dst_end;
    logic             bad;
    logic             good_acc;
    logic             bad_acc;
    logic             r_taken_q;
    logic             w_taken_q;
    logic             err_q;
    logic [OUT_W-1:0] outst_q;

    // ------------------------------
    // request check
    // ------------------------------
    assign src_offs = req_src_addr_i[OFFS_W-1:0];
    assign dst_offs = req_dst_addr_i[OFFS_W-1:0];
    // end offsets, one past the last byte
    assign src_end  = (LEN_W + 1)'(src_offs) + (LEN_W + 1)'(req_len_i);
    assign dst_end  = (LEN_W + 1)'(dst_offs) + (LEN_W + 1)'(req_len_i);
    assign bad      = (req_len_i == '0) ||
                      (src_end > (LEN_W + 1)'(STRB_W)) ||
                      (dst_end > (LEN_W + 1)'(STRB_W));

    // ------------------------------
    // fork into the two queues
    // ------------------------------
    // each side may take its copy first, the other catches up later
    assign r_valid_o = req_valid_i & ~bad & ~err_q & ~r_taken_q;
    assign w_valid_o = req_valid_i & ~bad & ~err_q & ~w_taken_q;
    assign good_acc  = req_valid_i & ~bad & ~err_q &
                       (r_taken_q | r_ready_i) & (w_taken_q | w_ready_i);
    // a reject waits for older copies, keeping responses in order
    assign bad_acc   = req_valid_i & bad & ~err_q & (outst_q == '0);
    assign req_ready_o = good_acc | bad_acc;

    assign r_req_o.addr  = {req_src_addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign r_req_o.shift = src_offs - dst_offs;
    assign w_req_o.addr  = {req_dst_addr_i[ADDR_W-1:OFFS_W], {OFFS_W{1'b0}}};
    assign w_req_o.first = dst_offs;
    assign w_req_o.last  = OFFS_W'(dst_end - 1'b1);

    // ------------------------------
    // response merge
    // ------------------------------
    // a pending error goes out first and holds back done
    assign rsp_valid_o  = err_q | done_valid_i;
    assign rsp_error_o  = err_q;
    assign done_ready_o = rsp_ready_i & ~err_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            r_taken_q <= 1'b0;
            w_taken_q <= 1'b0;
            err_q     <= 1'b0;
            outst_q   <= '0;
        end else begin
            if (good_acc) begin
                r_taken_q <= 1'b0;
                w_taken_q <= 1'b0;
            end else begin
                if (r_valid_o && r_ready_i) begin
                    r_taken_q <= 1'b1;
                end
                if (w_valid_o && w_ready_i) begin
                    w_taken_q <= 1'b1;
                end
            end
            if (bad_acc) begin
                err_q <= 1'b1;
            end else if (err_q && rsp_ready_i) begin
                err_q <= 1'b0;
            end
            // copies in flight between intake and done
            if (good_acc && !(done_valid_i && done_ready_o)) begin
                outst_q <= outst_q + 1'b1;
            end else if (!good_acc && done_valid_i && done_ready_o) begin
                outst_q <= outst_q - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dma_write_engine.sv
// Write side of the copy engine.
// Pairs a write order with an aligned data word, writes it with byte
// enables over the covered bytes and reports each finished write.

`timescale 1ns/1ns
`default_nettype none

module dma_write_engine (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   ord_valid_i,
    output logic                   ord_ready_o,
    input  dma_cfg_pkg::w_dp_req_t ord_i,
    input  logic                   data_valid_i,
    output logic                   data_ready_o,
    input  dma_cfg_pkg::data_t     data_i,
    output logic                   bus_req_o,
    output dma_cfg_pkg::addr_t     bus_addr_o,
    output dma_cfg_pkg::data_t     bus_wdata_o,
    output dma_cfg_pkg::strb_t     bus_be_o,
    input  logic                   bus_gnt_i,
    output logic                   done_valid_o,
    input  logic                   done_ready_i
);

    import dma_cfg_pkg::*;

    logic fire;
    logic done_q;

    // need an order, its data and a free done slot
    assign bus_req_o   = ord_valid_i & data_valid_i & ~done_q;
    assign bus_addr_o  = ord_i.addr;
    assign bus_wdata_o = data_i;
    assign fire        = bus_req_o & bus_gnt_i;

    // both queues pop on the grant edge
    assign ord_ready_o  = fire;
    assign data_ready_o = fire;
    assign done_valid_o = done_q;

    // byte mask from first through last offset
    always_comb begin
        for (int i = 0; i < STRB_W; i++) begin
            bus_be_o[i] = (i >= int'(ord_i.first)) && (i <= int'(ord_i.last));
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else if (fire) begin
            done_q <= 1'b1;
        end else if (done_ready_i) begin
            done_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire
